//--- icacheSys.f
design/cacheGeomPkg.sv
design/refillBusPkg.sv
design/lineSram.sv
design/tagArray.sv
design/refillUnit.sv
design/cacheCtrl.sv
design/icacheTop.sv
verification/refillMemModel.sv
verification/cacheProtocol_checker.sv
verification/icacheTb.sv

//--- Makefile
# Verilator flow for icacheSys, override any variable on the command line

VERILATOR ?= verilator
TOP       ?= icacheTb
FILELIST  ?= icacheSys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit code
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/icacheTb.sv
`timescale 1ns/100ps

module icacheTb
  import cacheGeomPkg::*;
  import refillBusPkg::*;
();

  localparam int    SEED        = 92;
  localparam int    NUM_REQS    = 400;
  // worst miss covers ready gap, beat latency, four beats, fill and replay plus stalls
  localparam int    MISS_CYCLES = 30;
  localparam int    MAX_CYCLES  = NUM_REQS * MISS_CYCLES + 200;
  localparam word_t MEM_PATTERN = 64'h5a5a_c3c3_0ff0_9669;

  logic        clk;
  logic        rst_n;
  logic        reqValid;
  logic        reqReady;
  cacheReq_t   req;
  logic        respValid;
  logic        respReady;
  cacheResp_t  resp;
  logic        lineReqValid;
  logic        lineReqReady;
  lineReq_t    lineReq;
  logic        beatValid;
  refillBeat_t beat;

  // reference cache state
  tag_t     modelTag [2][NUM_SETS];
  logic     modelValid [2][NUM_SETS];
  way_t     modelLru [NUM_SETS];
  word_t    expWordQ [$];
  logic     expRefillQ [$];
  lineReq_t expLineQ [$];

  int         seed;
  int         cycleCount;
  int         sentCount;
  int         respCount;
  int         lineReqCount;
  logic       reqTaken;
  logic       hitAccPrev;
  logic       hitDue;
  logic       holdPending;
  cacheResp_t heldResp;
  tag_t       tagPool [3];

  initial clk = 1'b0;
  always #10 clk = ~clk;

  icacheTop uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid),
    .reqReady_o     (reqReady),
    .req_i          (req),
    .respValid_o    (respValid),
    .respReady_i    (respReady),
    .resp_o         (resp),
    .lineReqValid_o (lineReqValid),
    .lineReqReady_i (lineReqReady),
    .lineReq_o      (lineReq),
    .beatValid_i    (beatValid),
    .beat_i         (beat)
  );

  refillMemModel #(
    .MEM_PATTERN (MEM_PATTERN),
    .SEED        (SEED)
  ) memModel (
    .clk            (clk),
    .rst_n          (rst_n),
    .lineReqValid_i (lineReqValid),
    .lineReqReady_o (lineReqReady),
    .lineReq_i      (lineReq),
    .beatValid_o    (beatValid),
    .beat_o         (beat)
  );

  // memory content is the pattern xor word address in both halves
  function automatic word_t memWord(addr_t a);
    addr_t wordAddr;
    wordAddr = {a[ADDR_W-1:3], 3'b000};
    return MEM_PATTERN ^ {2{wordAddr}};
  endfunction

  // few sets and three tags each so evictions happen
  function automatic addr_t randomAddr();
    tag_t     tag;
    index_t   idx;
    wordSel_t sel;
    tag = tagPool[$unsigned($random(seed)) % 3];
    idx = index_t'($unsigned($random(seed)) % 4);
    sel = wordSel_t'($unsigned($random(seed)) % 4);
    return {tag, idx, sel, 3'b000};
  endfunction

  // returns hit and fills the invalid or lru way on a miss
  function automatic logic modelAccess(addr_t a);
    index_t idx;
    tag_t   tag;
    way_t   way;
    logic   hit;
    idx = a[OFFSET_W +: INDEX_W];
    tag = a[ADDR_W-1 -: TAG_W];
    hit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (modelValid[w][idx] && modelTag[w][idx] == tag) begin
        hit = 1'b1;
        way = way_t'(w);
      end
    end
    if (!hit) begin
      if (!modelValid[0][idx]) way = 1'b0;
      else if (!modelValid[1][idx]) way = 1'b1;
      else way = modelLru[idx];
      modelValid[way][idx] = 1'b1;
      modelTag[way][idx]   = tag;
    end
    modelLru[idx] = ~way;
    return hit;
  endfunction

  task automatic failStop(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkResp(input cacheResp_t got, input cacheResp_t exp);
    if (got !== exp) begin
      failStop($sformatf("Mismatch resp_o.data: got %h expected %h", got.data, exp.data));
    end
  endtask

  task automatic checkLineReq(input lineReq_t got, input lineReq_t exp);
    if (got !== exp) begin
      failStop($sformatf("Mismatch lineReq_o.lineAddr: got %h expected %h",
                         got.lineAddr, exp.lineAddr));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      failStop($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  // sampled on the rising edge with inputs settled since the falling edge
  always @(posedge clk) begin : monitor
    logic       hit;
    lineReq_t   expLine;
    cacheResp_t expResp;
    if (rst_n) begin
      cycleCount++;
      if (cycleCount > MAX_CYCLES) failStop("timeout, the cache stopped answering");
      if (uut.protoChk.failCount != 0) failStop("protocol assertion failed");
      // response held under back-pressure
      if (holdPending) begin
        checkFlag("respValid_o", respValid, 1'b1);
        checkResp(resp, heldResp);
      end
      holdPending = respValid && !respReady;
      heldResp    = resp;
      if (holdPending) checkFlag("reqReady_o", reqReady, 1'b0);
      // hit answers one cycle after acceptance when the slot is free
      if (hitDue) checkFlag("respValid_o", respValid, 1'b1);
      hitDue     = hitAccPrev && (!respValid || respReady);
      hitAccPrev = 1'b0;
      // line request belongs to the last accepted request
      if (lineReqValid && lineReqReady) begin
        if (expLineQ.size() == 0) failStop("line request raised with none predicted");
        checkLineReq(lineReq, expLineQ.pop_front());
        lineReqCount++;
      end
      if (respValid && respReady) begin
        if (expWordQ.size() == 0) failStop("response with no request outstanding");
        expResp.data = expWordQ.pop_front();
        checkResp(resp, expResp);
        respCount++;
      end
      if (reqValid && reqReady) begin
        // previous request has finished its refill by now
        if (expRefillQ.size() != 0) begin
          checkFlag("lineReqValid_o handshake", lineReqCount != 0, expRefillQ.pop_front());
        end
        lineReqCount = 0;
        hit = modelAccess(req.addr);
        expWordQ.push_back(memWord(req.addr));
        expRefillQ.push_back(!hit);
        if (!hit) begin
          expLine.lineAddr = {req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
          expLineQ.push_back(expLine);
        end
        hitAccPrev = hit;
        reqTaken   = 1'b1;
        sentCount++;
      end
    end
  end

  initial begin
    seed         = SEED;
    cycleCount   = 0;
    sentCount    = 0;
    respCount    = 0;
    lineReqCount = 0;
    reqTaken     = 1'b0;
    hitAccPrev   = 1'b0;
    hitDue       = 1'b0;
    holdPending  = 1'b0;
    heldResp     = '0;
    tagPool[0]   = 21'h00001;
    tagPool[1]   = 21'h0abcd;
    tagPool[2]   = 21'h1f0f0;
    for (int s = 0; s < NUM_SETS; s++) begin
      modelValid[0][s] = 1'b0;
      modelValid[1][s] = 1'b0;
      modelLru[s]      = 1'b0;
      modelTag[0][s]   = '0;
      modelTag[1][s]   = '0;
    end
    rst_n     = 1'b0;
    reqValid  = 1'b0;
    req       = '0;
    respReady = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // idle state straight out of reset
    @(posedge clk);
    checkFlag("respValid_o", respValid, 1'b0);
    checkFlag("lineReqValid_o", lineReqValid, 1'b0);
    checkFlag("reqReady_o", reqReady, 1'b1);
    // new request only after the previous one was taken
    while (sentCount < NUM_REQS || reqValid) begin
      @(negedge clk);
      respReady = ($unsigned($random(seed)) % 4) != 0;
      if (reqTaken || !reqValid) begin
        reqTaken = 1'b0;
        reqValid = (sentCount < NUM_REQS) && (($unsigned($random(seed)) % 4) != 0);
        req.addr = randomAddr();
      end
    end
    // drain the last responses
    while (respCount < NUM_REQS) begin
      @(negedge clk);
      respReady = ($unsigned($random(seed)) % 4) != 0;
    end
    @(negedge clk);
    // refill outcome of the final request
    if (expRefillQ.size() != 0) begin
      checkFlag("lineReqValid_o handshake", lineReqCount != 0, expRefillQ.pop_front());
    end
    if (uut.protoChk.failCount == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      failStop("protocol assertion failures recorded during the run");
    end
  end

endmodule

//--- verification/cacheProtocol_checker.sv
`timescale 1ns/100ps

module cacheProtocol_checker
  import cacheGeomPkg::*;
  import refillBusPkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        reqValid_i,
  input logic        reqReady_i,
  input cacheReq_t   req_i,
  input logic        respValid_i,
  input logic        respReady_i,
  input cacheResp_t  resp_i,
  input logic        lineReqValid_i,
  input logic        lineReqReady_i,
  input lineReq_t    lineReq_i,
  input logic        beatValid_i,
  input refillBeat_t beat_i
);

  // refill open from line request handshake to last beat
  logic refillOpen;
  // read by the testbench top
  int   failCount = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refillOpen <= 1'b0;
    end else if (lineReqValid_i && lineReqReady_i) begin
      refillOpen <= 1'b1;
    end else if (beatValid_i && beat_i.last) begin
      refillOpen <= 1'b0;
    end
  end

  reqHold: assert property (@(posedge clk) disable iff (!rst_n)
      reqValid_i && !reqReady_i |=> reqValid_i && $stable(req_i))
    else begin
      failCount = failCount + 1;
      $error("request dropped or changed before it was accepted");
    end

  respHold: assert property (@(posedge clk) disable iff (!rst_n)
      respValid_i && !respReady_i |=> respValid_i && $stable(resp_i))
    else begin
      failCount = failCount + 1;
      $error("response dropped or changed under back-pressure");
    end

  lineReqHold: assert property (@(posedge clk) disable iff (!rst_n)
      lineReqValid_i && !lineReqReady_i |=> lineReqValid_i && $stable(lineReq_i))
    else begin
      failCount = failCount + 1;
      $error("line request dropped or changed before it was accepted");
    end

  // beats only inside an open refill
  beatInRefill: assert property (@(posedge clk) disable iff (!rst_n)
      beatValid_i |-> refillOpen)
    else begin
      failCount = failCount + 1;
      $error("refill beat with no line request outstanding");
    end

  // one miss at a time
  singleRefill: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(lineReqValid_i) |-> !refillOpen)
    else begin
      failCount = failCount + 1;
      $error("second line request while a refill is open");
    end

  stallOnMiss: assert property (@(posedge clk) disable iff (!rst_n)
      refillOpen |-> !reqReady_i)
    else begin
      failCount = failCount + 1;
      $error("request ready while a refill is open");
    end

endmodule

bind icacheTop cacheProtocol_checker protoChk (
  .clk            (clk),
  .rst_n          (rst_n),
  .reqValid_i     (reqValid_i),
  .reqReady_i     (reqReady_o),
  .req_i          (req_i),
  .respValid_i    (respValid_o),
  .respReady_i    (respReady_i),
  .resp_i         (resp_o),
  .lineReqValid_i (lineReqValid_o),
  .lineReqReady_i (lineReqReady_i),
  .lineReq_i      (lineReq_o),
  .beatValid_i    (beatValid_i),
  .beat_i         (beat_i)
);

//--- verification/refillMemModel.sv
`timescale 1ns/100ps

module refillMemModel
  import cacheGeomPkg::*;
  import refillBusPkg::*;
#(
  parameter word_t MEM_PATTERN = '0,
  parameter int    SEED        = 1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        lineReqValid_i,
  output logic        lineReqReady_o,
  input  lineReq_t    lineReq_i,
  output logic        beatValid_o,
  output refillBeat_t beat_o
);

  int    seed;
  int    gap;
  int    beatIdx;
  addr_t lineAddr;
  addr_t wordAddr;

  // one refill at a time, inputs change on the falling edge
  initial begin
    seed           = SEED;
    lineReqReady_o = 1'b0;
    beatValid_o    = 1'b0;
    beat_o         = '0;
    @(posedge rst_n);
    forever begin
      // short idle gap before ready goes up
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(negedge clk);
      @(negedge clk);
      lineReqReady_o = 1'b1;
      // wait for the handshake edge
      do begin
        @(posedge clk);
      end while (!lineReqValid_i);
      lineAddr = lineReq_i.lineAddr;
      @(negedge clk);
      lineReqReady_o = 1'b0;
      // access latency before first beat
      gap = $unsigned($random(seed)) % 8;
      repeat (gap) @(negedge clk);
      // lowest word first, back to back
      for (beatIdx = 0; beatIdx < BEATS_PER_LINE; beatIdx++) begin
        wordAddr    = lineAddr + addr_t'(beatIdx * 8);
        beatValid_o = 1'b1;
        beat_o.data = MEM_PATTERN ^ {2{wordAddr}};
        beat_o.last = (beatIdx == BEATS_PER_LINE - 1);
        @(negedge clk);
      end
      beatValid_o = 1'b0;
    end
  end

endmodule

//--- design/icacheTop.sv
`timescale 1ns/100ps

module icacheTop
  import cacheGeomPkg::*;
  import refillBusPkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // core side
  input  logic        reqValid_i,
  output logic        reqReady_o,
  input  cacheReq_t   req_i,
  output logic        respValid_o,
  input  logic        respReady_i,
  output cacheResp_t  resp_o,
  // memory side
  output logic        lineReqValid_o,
  input  logic        lineReqReady_i,
  output lineReq_t    lineReq_o,
  input  logic        beatValid_i,
  input  refillBeat_t beat_i
);

  index_t     lookupIndex;
  tag_t       lookupTag;
  logic       hit;
  way_t       hitWay;
  way_t       victimWay;
  logic       touch;
  logic       fill;
  way_t       fillWay;
  logic [1:0] sramEn;
  logic [1:0] sramWe;
  index_t     sramIndex;
  line_t      way0Line;
  line_t      way1Line;
  logic       refillStart;
  addr_t      refillAddr;
  logic       fillDone;
  line_t      fillLine;

  cacheCtrl ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .reqReady_o    (reqReady_o),
    .req_i         (req_i),
    .respValid_o   (respValid_o),
    .respReady_i   (respReady_i),
    .resp_o        (resp_o),
    .lookupIndex_o (lookupIndex),
    .lookupTag_o   (lookupTag),
    .hit_i         (hit),
    .hitWay_i      (hitWay),
    .victimWay_i   (victimWay),
    .touch_o       (touch),
    .fill_o        (fill),
    .fillWay_o     (fillWay),
    .sramEn_o      (sramEn),
    .sramWe_o      (sramWe),
    .sramIndex_o   (sramIndex),
    .way0Line_i    (way0Line),
    .way1Line_i    (way1Line),
    .refillStart_o (refillStart),
    .refillAddr_o  (refillAddr),
    .fillDone_i    (fillDone),
    .fillLine_i    (fillLine)
  );

  tagArray tags (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupIndex_i (lookupIndex),
    .lookupTag_i   (lookupTag),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .touch_i       (touch),
    .fill_i        (fill),
    .fillWay_i     (fillWay)
  );

  refillUnit refill (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (refillStart),
    .startAddr_i    (refillAddr),
    .lineReqValid_o (lineReqValid_o),
    .lineReqReady_i (lineReqReady_i),
    .lineReq_o      (lineReq_o),
    .beatValid_i    (beatValid_i),
    .beat_i         (beat_i),
    .fillDone_o     (fillDone),
    .line_o         (fillLine)
  );

  // both ways share index and fill data
  lineSram way0Mem (
    .clk     (clk),
    .en_i    (sramEn[0]),
    .we_i    (sramWe[0]),
    .index_i (sramIndex),
    .wdata_i (fillLine),
    .rdata_o (way0Line)
  );

  lineSram way1Mem (
    .clk     (clk),
    .en_i    (sramEn[1]),
    .we_i    (sramWe[1]),
    .index_i (sramIndex),
    .wdata_i (fillLine),
    .rdata_o (way1Line)
  );

endmodule

//--- design/cacheCtrl.sv
`timescale 1ns/100ps

module cacheCtrl
  import cacheGeomPkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // core request
  input  logic       reqValid_i,
  output logic       reqReady_o,
  input  cacheReq_t  req_i,
  // core response
  output logic       respValid_o,
  input  logic       respReady_i,
  output cacheResp_t resp_o,
  // tag array
  output index_t     lookupIndex_o,
  output tag_t       lookupTag_o,
  input  logic       hit_i,
  input  way_t       hitWay_i,
  input  way_t       victimWay_i,
  output logic       touch_o,
  output logic       fill_o,
  output way_t       fillWay_o,
  // line memories
  output logic [1:0] sramEn_o,
  output logic [1:0] sramWe_o,
  output index_t     sramIndex_o,
  input  line_t      way0Line_i,
  input  line_t      way1Line_i,
  // refill
  output logic       refillStart_o,
  output addr_t      refillAddr_o,
  input  logic       fillDone_i,
  input  line_t      fillLine_i
);

  typedef enum logic [2:0] {IDLE, LOOKUP, MISS, FILL, REPLAY} ctrlState_t;

  ctrlState_t state;
  ctrlState_t stateNext;
  cacheReq_t  reqLatch;
  cacheResp_t respQ;
  logic       respValidQ;
  logic       slotFree;
  logic       accept;
  logic       respond;
  line_t      hitLine;
  word_t      hitWord;

  // output slot empty or drained this edge
  assign slotFree = !respValidQ || respReady_i;
  assign respond  = (state == LOOKUP) && hit_i && slotFree;

  // ready in idle, or behind a hit that answers now
  assign reqReady_o = ((state == IDLE) || (state == LOOKUP && hit_i)) && slotFree;
  assign accept     = reqValid_i && reqReady_o;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE:    if (accept) stateNext = LOOKUP;
      LOOKUP: begin
        if (!hit_i) begin
          stateNext = MISS;
        end else if (slotFree) begin
          stateNext = accept ? LOOKUP : IDLE;
        end
      end
      MISS:    if (fillDone_i) stateNext = FILL;
      FILL:    stateNext = REPLAY;
      REPLAY:  stateNext = LOOKUP;
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  // request latch, used through lookup, miss and replay
  always_ff @(posedge clk) begin
    if (accept) begin
      reqLatch <= req_i;
    end
  end

  assign lookupIndex_o = addrIndex(reqLatch.addr);
  assign lookupTag_o   = addrTag(reqLatch.addr);
  assign touch_o       = respond;
  assign fill_o        = (state == FILL);
  assign fillWay_o     = victimWay_i;

  // read both ways on accept or replay, write victim on fill
  assign sramWe_o    = (state == FILL) ? (2'b01 << victimWay_i) : 2'b00;
  assign sramEn_o    = {2{accept || (state == REPLAY)}} | sramWe_o;
  assign sramIndex_o = accept ? addrIndex(req_i.addr) : addrIndex(reqLatch.addr);

  // miss found in lookup, refill request next cycle
  assign refillStart_o = (state == LOOKUP) && !hit_i;
  assign refillAddr_o  = reqLatch.addr;

  // word select from hit way
  assign hitLine = hitWay_i ? way1Line_i : way0Line_i;
  assign hitWord = hitLine[WORD_W*addrWordSel(reqLatch.addr) +: WORD_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      respValidQ <= 1'b0;
    end else if (respond) begin
      respValidQ <= 1'b1;
    end else if (respReady_i) begin
      respValidQ <= 1'b0;
    end
  end

  // held while back-pressured
  always_ff @(posedge clk) begin
    if (respond) begin
      respQ.data <= hitWord;
    end
  end

  assign respValid_o = respValidQ;
  assign resp_o      = respQ;

endmodule

//--- design/refillUnit.sv
`timescale 1ns/100ps

module refillUnit
  import cacheGeomPkg::*;
  import refillBusPkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_i,
  input  addr_t       startAddr_i,
  output logic        lineReqValid_o,
  input  logic        lineReqReady_i,
  output lineReq_t    lineReq_o,
  input  logic        beatValid_i,
  input  refillBeat_t beat_i,
  output logic        fillDone_o,
  output line_t       line_o
);

  logic     lineReqValidQ;
  lineReq_t lineReqQ;
  beatCnt_t beatCnt;
  line_t    lineBuf;
  logic     fillDoneQ;

  // request held until memory side takes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lineReqValidQ <= 1'b0;
    end else if (start_i) begin
      lineReqValidQ <= 1'b1;
    end else if (lineReqReady_i) begin
      lineReqValidQ <= 1'b0;
    end
  end

  // line aligned address
  always_ff @(posedge clk) begin
    if (start_i) begin
      lineReqQ.lineAddr <= {startAddr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end
  end

  // beat counter and done pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt   <= '0;
      fillDoneQ <= 1'b0;
    end else begin
      fillDoneQ <= beatValid_i && beat_i.last;
      if (beatValid_i) begin
        beatCnt <= beat_i.last ? '0 : beatCnt + 1'b1;
      end
    end
  end

  // lowest word arrives first
  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineBuf[WORD_W*beatCnt +: WORD_W] <= beat_i.data;
    end
  end

  assign lineReqValid_o = lineReqValidQ;
  assign lineReq_o      = lineReqQ;
  assign fillDone_o     = fillDoneQ;
  assign line_o         = lineBuf;

endmodule

//--- design/tagArray.sv
`timescale 1ns/100ps

module tagArray
  import cacheGeomPkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  index_t lookupIndex_i,
  input  tag_t   lookupTag_i,
  output logic   hit_o,
  output way_t   hitWay_o,
  output way_t   victimWay_o,
  input  logic   touch_i,
  input  logic   fill_i,
  input  way_t   fillWay_i
);

  // tag storage per way
  tag_t tagMem [2][NUM_SETS];
  // valid bits per way, one per set
  logic [NUM_SETS-1:0] validQ [2];
  // lru bit names the least recently used way
  logic [NUM_SETS-1:0] lruQ;

  logic way0Valid;
  logic way1Valid;
  logic way0Hit;
  logic way1Hit;

  assign way0Valid = validQ[0][lookupIndex_i];
  assign way1Valid = validQ[1][lookupIndex_i];

  // compare both ways at once
  assign way0Hit = way0Valid && (tagMem[0][lookupIndex_i] == lookupTag_i);
  assign way1Hit = way1Valid && (tagMem[1][lookupIndex_i] == lookupTag_i);

  assign hit_o    = way0Hit | way1Hit;
  assign hitWay_o = way_t'(way1Hit);

  // invalid way first, way 0 preferred
  always_comb begin
    if (!way0Valid) begin
      victimWay_o = 1'b0;
    end else if (!way1Valid) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = lruQ[lookupIndex_i];
    end
  end

  // new tag written on fill
  always_ff @(posedge clk) begin
    if (fill_i) begin
      tagMem[fillWay_i][lookupIndex_i] <= lookupTag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ[0] <= '0;
      validQ[1] <= '0;
      lruQ      <= '0;
    end else if (fill_i) begin
      validQ[fillWay_i][lookupIndex_i] <= 1'b1;
      // filled way is now most recent
      lruQ[lookupIndex_i] <= ~fillWay_i;
    end else if (touch_i) begin
      lruQ[lookupIndex_i] <= ~hitWay_o;
    end
  end

endmodule

//--- design/lineSram.sv
`timescale 1ns/100ps

module lineSram
  import cacheGeomPkg::*;
(
  input  logic   clk,
  input  logic   en_i,
  input  logic   we_i,
  input  index_t index_i,
  input  line_t  wdata_i,
  output line_t  rdata_o
);

  // behavioral single-port array, one line per set
  line_t memArray [NUM_SETS];
  line_t rdataQ;

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        // write leaves rdataQ untouched
        memArray[index_i] <= wdata_i;
      end else begin
        rdataQ <= memArray[index_i];
      end
    end
  end

  // registered read, output held while en_i low
  assign rdata_o = rdataQ;

endmodule

//--- design/refillBusPkg.sv
package refillBusPkg;

  import cacheGeomPkg::*;

  // beats per line refill, one word per beat
  localparam int BEATS_PER_LINE = 4;
  localparam int BEAT_CNT_W     = $clog2(BEATS_PER_LINE);

  typedef logic [BEAT_CNT_W-1:0] beatCnt_t;

  // line request toward memory
  // offset bits always zero
  typedef struct packed {
    addr_t lineAddr;
  } lineReq_t;

  // refill beat from memory, no back-pressure
  typedef struct packed {
    word_t data;
    logic  last;
  } refillBeat_t;

endpackage

//--- design/cacheGeomPkg.sv
package cacheGeomPkg;

  // address split, tag | index | offset
  localparam int ADDR_W   = 32;
  localparam int OFFSET_W = 5;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // line and word geometry
  localparam int WORD_W         = 64;
  localparam int LINE_W         = 256;
  localparam int NUM_SETS       = 1 << INDEX_W;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;
  localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [WORD_SEL_W-1:0] wordSel_t;
  typedef logic                  way_t;

  // core fetch request
  typedef struct packed {
    addr_t addr;
  } cacheReq_t;

  // one fetched word back to the core
  typedef struct packed {
    word_t data;
  } cacheResp_t;

  function automatic index_t addrIndex(addr_t a);
    return a[OFFSET_W +: INDEX_W];
  endfunction

  function automatic tag_t addrTag(addr_t a);
    return a[ADDR_W-1 -: TAG_W];
  endfunction

  // byte offset bits [2:0] ignored, requests are word aligned
  function automatic wordSel_t addrWordSel(addr_t a);
    return a[OFFSET_W-1 -: WORD_SEL_W];
  endfunction

endpackage
